// ==== hdl/codec_clock_gen.sv ====
// TDM timing for the codec, bick is clk/2 and a frame is 256 clk
// All outputs decode one free-running counter, so they never drift apart
`timescale 1ns/1ps
`default_nettype none

`include "eurorack_macros.svh"

module codec_clock_gen (
     input  logic clk
    ,input  logic arst_n
    ,tdm_timing_if.gen tim
);

    // cnt[0] is the bick phase, cnt[5:1] the bit, cnt[7:6] the slot
    logic [7:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 8'd1;
        end
    end

    // bick starts low after reset
    assign tim.bick = cnt[0];

    // High for slots 0 and 1
    assign tim.lrck = ~cnt[7];

    // bick rises on the edge that ends an even count
    assign tim.bick_rise = ~cnt[0];

    // bick falls on the edge that ends an odd count
    assign tim.bick_fall = cnt[0];

    // Bit 31 goes first, so the index counts down within a slot
    assign tim.bit_idx = ~cnt[5:1];

    assign tim.slot_idx = cnt[7:6];

    // Last clk of the frame, also the last bick_fall of slot 3
    assign tim.frame_end = (cnt == 8'(`EP_FRAME_CLKS - 1));

endmodule

`default_nettype wire

// ==== hdl/codec_power_ctrl.sv ====
// Codec power-up: pdn low for 2 frames, then 4 startup frames of silence
// sample_clk only pulses in RUN and stays there until reset
`timescale 1ns/1ps
`default_nettype none

`include "eurorack_macros.svh"

module codec_power_ctrl (
     input  logic clk
    ,input  logic arst_n
    ,tdm_timing_if.ctrl tim
    ,output logic pdn
    ,output logic run
    ,output logic sample_clk
);

    import eurorack_pkg::*;

    power_state_e state;
    logic [2:0]   frames;

    // Everything moves on frame boundaries only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= PDN_LOW;
            frames <= '0;
        end else if (tim.frame_end) begin
            case (state)
                PDN_LOW: begin
                    if (frames == 3'(`EP_PDN_FRAMES - 1)) begin
                        state  <= STARTUP;
                        frames <= '0;
                    end else begin
                        frames <= frames + 3'd1;
                    end
                end
                STARTUP: begin
                    if (frames == 3'(`EP_STARTUP_FRAMES - 1)) begin
                        state  <= RUN;
                        frames <= '0;
                    end else begin
                        frames <= frames + 3'd1;
                    end
                end
                RUN: begin
                    frames <= '0;
                end
                default: begin
                    state  <= PDN_LOW;
                    frames <= '0;
                end
            endcase
        end
    end

    assign pdn = (state != PDN_LOW);
    assign run = (state == RUN);

    // First pulse comes one frame after entering RUN
    assign sample_clk = tim.frame_end & run;

endmodule

`default_nettype wire

// ==== hdl/eurorack_macros.svh ====
// Widths, frame timing and calibration table for the audio path
// Calibration values are fixed at build time, gain 256 is unity
`ifndef EURORACK_MACROS_SVH
`define EURORACK_MACROS_SVH

// Codec format
`define EP_W              16
`define EP_CHANNELS       4
`define EP_SLOT_BITS      32
`define EP_FRAME_CLKS     256

// Power-up sequence, in frames
`define EP_PDN_FRAMES     2
`define EP_STARTUP_FRAMES 4

// Calibration arithmetic
`define EP_GAIN_W         9
`define EP_GAIN_SHIFT     8
`define EP_PROD_W         (`EP_W + `EP_GAIN_W + 2)

// Offsets, channels 0-3 are inputs and 4-7 are outputs
`define EP_CAL_OFFSET_0   (-16'sd212)
`define EP_CAL_OFFSET_1   (-16'sd187)
`define EP_CAL_OFFSET_2   (16'sd96)
`define EP_CAL_OFFSET_3   (-16'sd41)
`define EP_CAL_OFFSET_4   (16'sd305)
`define EP_CAL_OFFSET_5   (16'sd271)
`define EP_CAL_OFFSET_6   (-16'sd128)
`define EP_CAL_OFFSET_7   (16'sd64)

// Gains
`define EP_CAL_GAIN_0     9'd263
`define EP_CAL_GAIN_1     9'd259
`define EP_CAL_GAIN_2     9'd250
`define EP_CAL_GAIN_3     9'd268
`define EP_CAL_GAIN_4     9'd301
`define EP_CAL_GAIN_5     9'd296
`define EP_CAL_GAIN_6     9'd288
`define EP_CAL_GAIN_7     9'd310

`endif

// ==== hdl/eurorack_pkg.sv ====
// Shared types for the codec path
// The slot word is MSB first, the sample sits in the upper half
`default_nettype none

`include "eurorack_macros.svh"

package eurorack_pkg;

    typedef logic signed [`EP_W-1:0] sample_t;

    // One TDM slot, seen as shift bits or as sample plus padding
    typedef union packed {
        logic [`EP_SLOT_BITS-1:0] raw;
        struct packed {
            sample_t                         sample;
            logic [`EP_SLOT_BITS-`EP_W-1:0] pad;
        } fields;
    } slot_word_u;

    typedef enum logic [1:0] {
        PDN_LOW,
        STARTUP,
        RUN
    } power_state_e;

endpackage

`default_nettype wire

// ==== hdl/eurorack_top.sv ====
// Four-channel codec path with the mirror core, clk assumed 12 MHz
// clk and arst_n come straight from the pins, no PLL in front
`timescale 1ns/1ps
`default_nettype none

`include "eurorack_macros.svh"

module eurorack_top (
     input  logic clk
    ,input  logic arst_n
    ,output logic pdn
    ,output logic mclk
    ,output logic bick
    ,output logic lrck
    ,output logic sdin1
    ,input  logic sdout1
);

    import eurorack_pkg::*;

    tdm_timing_if tim ();

    logic    run;
    logic    sample_clk;
    sample_t sample_adc [`EP_CHANNELS];
    sample_t sample_dac [`EP_CHANNELS];
    sample_t cal_in [`EP_CHANNELS];
    sample_t cal_out [`EP_CHANNELS];

    codec_clock_gen clock_gen_instance (
         .clk    (clk)
        ,.arst_n (arst_n)
        ,.tim    (tim.gen)
    );

    codec_power_ctrl power_ctrl_instance (
         .clk        (clk)
        ,.arst_n     (arst_n)
        ,.tim        (tim.ctrl)
        ,.pdn        (pdn)
        ,.run        (run)
        ,.sample_clk (sample_clk)
    );

    // cal_busy inside sample_cal ends 8 clk after sample_clk,
    // long before the next frame end snapshots sample_dac
    sample_cal cal_instance (
         .clk        (clk)
        ,.arst_n     (arst_n)
        ,.sample_clk (sample_clk)
        ,.in_adc     (sample_adc)
        ,.in_core    (cal_out)
        ,.cal_in     (cal_in)
        ,.cal_dac    (sample_dac)
    );

    // Mirror core
    assign cal_out = cal_in;

    tdm_shifter shifter_instance (
         .clk    (clk)
        ,.arst_n (arst_n)
        ,.tim    (tim.shift)
        ,.run    (run)
        ,.sdout1 (sdout1)
        ,.sdin1  (sdin1)
        ,.dac    (sample_dac)
        ,.adc    (sample_adc)
    );

    // Codec master clock stops while powered down
    assign mclk = clk & pdn;
    assign bick = tim.bick;
    assign lrck = tim.lrck;

endmodule

`default_nettype wire

// ==== hdl/sample_cal.sv ====
// Offset and gain calibration, one shared multiplier for eight channels
// Channels 0-3 take the inverted ADC input, 4-7 the core output
// Results update over the 8 clk after sample_clk
`timescale 1ns/1ps
`default_nettype none

`include "eurorack_macros.svh"

module sample_cal (
     input  logic clk
    ,input  logic arst_n
    ,input  logic sample_clk
    ,input  eurorack_pkg::sample_t in_adc [`EP_CHANNELS]
    ,input  eurorack_pkg::sample_t in_core [`EP_CHANNELS]
    ,output eurorack_pkg::sample_t cal_in [`EP_CHANNELS]
    ,output eurorack_pkg::sample_t cal_dac [`EP_CHANNELS]
);

    import eurorack_pkg::*;

    logic [2:0]                   ch;
    logic                         cal_busy;
    sample_t                      raw;
    sample_t                      offset;
    logic [`EP_GAIN_W-1:0]        gain;
    logic signed [`EP_W:0]        biased;
    logic signed [`EP_PROD_W-1:0] scaled;
    logic signed [`EP_PROD_W-1:0] shifted;
    logic                         in_range;
    sample_t                      result;

    function automatic sample_t cal_offset(input logic [2:0] idx);
        case (idx)
            3'd0:    cal_offset = `EP_CAL_OFFSET_0;
            3'd1:    cal_offset = `EP_CAL_OFFSET_1;
            3'd2:    cal_offset = `EP_CAL_OFFSET_2;
            3'd3:    cal_offset = `EP_CAL_OFFSET_3;
            3'd4:    cal_offset = `EP_CAL_OFFSET_4;
            3'd5:    cal_offset = `EP_CAL_OFFSET_5;
            3'd6:    cal_offset = `EP_CAL_OFFSET_6;
            default: cal_offset = `EP_CAL_OFFSET_7;
        endcase
    endfunction

    function automatic logic [`EP_GAIN_W-1:0] cal_gain(input logic [2:0] idx);
        case (idx)
            3'd0:    cal_gain = `EP_CAL_GAIN_0;
            3'd1:    cal_gain = `EP_CAL_GAIN_1;
            3'd2:    cal_gain = `EP_CAL_GAIN_2;
            3'd3:    cal_gain = `EP_CAL_GAIN_3;
            3'd4:    cal_gain = `EP_CAL_GAIN_4;
            3'd5:    cal_gain = `EP_CAL_GAIN_5;
            3'd6:    cal_gain = `EP_CAL_GAIN_6;
            default: cal_gain = `EP_CAL_GAIN_7;
        endcase
    endfunction

    // Analog front end inverts, plain NOT is close enough to negation
    assign raw    = ch[2] ? in_core[ch[1:0]] : ~in_adc[ch[1:0]];
    assign offset = cal_offset(ch);
    assign gain   = cal_gain(ch);

    assign biased  = {raw[`EP_W-1], raw} + {offset[`EP_W-1], offset};
    assign scaled  = biased * $signed({1'b0, gain});
    assign shifted = scaled >>> `EP_GAIN_SHIFT;

    // Fits in 16 bits when the bits above the sample all match its sign
    assign in_range = (&shifted[`EP_PROD_W-1:`EP_W-1]) | ~(|shifted[`EP_PROD_W-1:`EP_W-1]);
    assign result   = in_range ? shifted[`EP_W-1:0]
                    : {shifted[`EP_PROD_W-1], {(`EP_W-1){~shifted[`EP_PROD_W-1]}}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ch       <= '0;
            cal_busy <= 1'b0;
            for (int k = 0; k < `EP_CHANNELS; k++) begin
                cal_in[k]  <= '0;
                cal_dac[k] <= '0;
            end
        end else if (sample_clk) begin
            ch       <= '0;
            cal_busy <= 1'b1;
        end else if (cal_busy) begin
            if (ch[2]) begin
                cal_dac[ch[1:0]] <= result;
            end else begin
                cal_in[ch[1:0]] <= result;
            end
            ch <= ch + 3'd1;
            if (ch == 3'd7) begin
                cal_busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tdm_shifter.sv ====
// Serial side of the codec link, four 32-bit slots per frame, MSB first
// Output words are captured at frame end, so an input returns two frames later
// Zero slots are sent whenever run is low
`timescale 1ns/1ps
`default_nettype none

`include "eurorack_macros.svh"

module tdm_shifter (
     input  logic clk
    ,input  logic arst_n
    ,tdm_timing_if.shift tim
    ,input  logic run
    ,input  logic sdout1
    ,output logic sdin1
    ,input  eurorack_pkg::sample_t dac [`EP_CHANNELS]
    ,output eurorack_pkg::sample_t adc [`EP_CHANNELS]
);

    import eurorack_pkg::*;

    slot_word_u tx;
    slot_word_u tx_load;
    slot_word_u rx;
    slot_word_u rx_next;
    sample_t    tx_hold [1:`EP_CHANNELS-1];
    sample_t    staging [`EP_CHANNELS];
    logic [1:0] next_slot;
    logic       slot_last_fall;
    logic       slot_last_rise;

    assign next_slot      = tim.slot_idx + 2'd1;
    assign slot_last_fall = tim.bick_fall & (tim.bit_idx == '0);
    assign slot_last_rise = tim.bick_rise & (tim.bit_idx == '0);

    // Slot 0 loads straight from dac at frame end, the rest from the snapshot
    always_comb begin
        tx_load.fields.sample = '0;
        tx_load.fields.pad    = '0;
        if (run) begin
            tx_load.fields.sample = tim.frame_end ? dac[0] : tx_hold[next_slot];
        end
    end

    always_ff @(posedge clk) begin
        if (tim.frame_end) begin
            for (int k = 1; k < `EP_CHANNELS; k++) begin
                tx_hold[k] <= dac[k];
            end
        end
    end

    // New word lands on the last fall of the previous slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx.raw <= '0;
        end else if (slot_last_fall) begin
            tx <= tx_load;
        end else if (tim.bick_fall) begin
            tx.raw <= {tx.raw[`EP_SLOT_BITS-2:0], 1'b0};
        end
    end

    assign sdin1 = tx.raw[`EP_SLOT_BITS-1];

    assign rx_next.raw = {rx.raw[`EP_SLOT_BITS-2:0], sdout1};

    always_ff @(posedge clk) begin
        if (tim.bick_rise) begin
            rx <= rx_next;
        end
        if (slot_last_rise) begin
            staging[tim.slot_idx] <= rx_next.fields.sample;
        end
    end

    // Slot 3 reaches staging one clk before frame end
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < `EP_CHANNELS; k++) begin
                adc[k] <= '0;
            end
        end else if (tim.frame_end) begin
            adc <= staging;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tdm_timing_if.sv ====
// Frame timing from the clock generator
// Strobes are one clk wide and precede the bick edge they name
`timescale 1ns/1ps
`default_nettype none

`include "eurorack_macros.svh"

interface tdm_timing_if;

    logic                                bick;
    logic                                lrck;
    logic                                bick_rise;
    logic                                bick_fall;
    logic [$clog2(`EP_CHANNELS)-1:0]     slot_idx;
    logic [$clog2(`EP_SLOT_BITS)-1:0]    bit_idx;
    logic                                frame_end;

    modport gen (
        output bick, lrck, bick_rise, bick_fall, slot_idx, bit_idx, frame_end
    );

    modport ctrl (
        input frame_end
    );

    modport shift (
        input bick_rise, bick_fall, slot_idx, bit_idx, frame_end
    );

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the codec path simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module eurorack_tb -o eurorack_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/eurorack_sim > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $RUN_STATUS -ne 0 ]; then
    echo "Simulator exited with status $RUN_STATUS"
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== test/codec_model.sv ====
// Behavioral TDM codec, follows the DUT frame from reset
// Sends one 16-bit sample per slot from in_q, zero once the queue runs out
`timescale 1ns/1ps
`default_nettype none

module codec_model (
     input  logic clk
    ,input  logic arst_n
    ,input  logic bick
    ,input  logic sdin1
    ,output logic sdout1
);

    logic [15:0] in_q [$];
    logic [15:0] out_q [$];
    logic [7:0]  pos;
    int          frame;
    logic [15:0] word;
    logic [15:0] cap;

    initial sdout1 = 1'b0;

    // Position within the frame, same count as the codec link
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pos   <= '0;
            frame <= 0;
        end else begin
            pos <= pos + 8'd1;
            if (pos == 8'd255) begin
                frame <= frame + 1;
            end
        end
    end

    // Even positions set up the next input bit, odd ones read the output
    always @(negedge clk) begin : serial_io
        int idx;
        int bitn;
        idx  = frame * 4 + int'(pos[7:6]);
        bitn = int'(pos[5:1]);
        if (!pos[0]) begin
            word = (idx < in_q.size()) ? in_q[idx] : 16'h0000;
            sdout1 <= (bitn < 16) ? word[15 - bitn] : 1'b0;
        end else if (arst_n && bick) begin
            if (bitn < 16) begin
                cap[15 - bitn] = sdin1;
            end
            if (bitn == 31) begin
                out_q.push_back(cap);
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/eurorack_tb.sv ====
// Testbench for the codec path, stops at the first mismatch
// Output slot k of frame n+2 carries input slot k of frame n
`timescale 1ns/1ps
`default_nettype none

`include "eurorack_macros.svh"

module eurorack_tb;

    localparam int RUN1_FRAMES    = 30;
    localparam int RUN2_FRAMES    = 10;
    localparam int SAT_FRAME      = 26;
    localparam int QUIET_FRAMES   = 8;
    localparam int TIMEOUT_CYCLES = (RUN1_FRAMES + RUN2_FRAMES + 4) * `EP_FRAME_CLKS;

    logic clk;
    logic arst_n;
    logic pdn;
    logic mclk;
    logic bick;
    logic lrck;
    logic sdin1;
    logic sdout1;

    logic [31:0] lfsr;
    logic [15:0] in_hist [$];
    int          cycles;
    int          mclk_edges;
    logic        prev_bick;
    logic        prev_lrck;
    logic        mon_valid;
    logic        lr_seen;
    int          lr_per;
    int          lr_high;

    int offsets [8] = '{`EP_CAL_OFFSET_0, `EP_CAL_OFFSET_1, `EP_CAL_OFFSET_2, `EP_CAL_OFFSET_3,
                        `EP_CAL_OFFSET_4, `EP_CAL_OFFSET_5, `EP_CAL_OFFSET_6, `EP_CAL_OFFSET_7};
    int gains [8] = '{`EP_CAL_GAIN_0, `EP_CAL_GAIN_1, `EP_CAL_GAIN_2, `EP_CAL_GAIN_3,
                      `EP_CAL_GAIN_4, `EP_CAL_GAIN_5, `EP_CAL_GAIN_6, `EP_CAL_GAIN_7};

    eurorack_top dut0 (
         .clk    (clk)
        ,.arst_n (arst_n)
        ,.pdn    (pdn)
        ,.mclk   (mclk)
        ,.bick   (bick)
        ,.lrck   (lrck)
        ,.sdin1  (sdin1)
        ,.sdout1 (sdout1)
    );

    codec_model model0 (
         .clk    (clk)
        ,.arst_n (arst_n)
        ,.bick   (bick)
        ,.sdin1  (sdin1)
        ,.sdout1 (sdout1)
    );

    always #10 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_sample(output logic [15:0] v);
        v = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // Offset in 17 bits, gain, arithmetic shift by 8, clamp to 16 bits
    function automatic int cal_ref(input int s, input int ch);
        int p;
        p = ((s + offsets[ch]) * gains[ch]) >>> 8;
        if (p > 32767) begin
            p = 32767;
        end else if (p < -32768) begin
            p = -32768;
        end
        return p;
    endfunction

    function automatic logic [15:0] expected_out(input logic [15:0] x, input int slot);
        int v;
        v = cal_ref(int'($signed(~x)), slot);
        v = cal_ref(v, slot + 4);
        return v[15:0];
    endfunction

    task automatic fill_inputs(input int frames, input logic with_sat);
        logic [15:0] v;
        in_hist.delete();
        model0.in_q.delete();
        model0.out_q.delete();
        for (int i = 0; i < frames * 4; i++) begin
            random_sample(v);
            if (with_sat && i / 4 == SAT_FRAME) begin
                v = 16'h8000;
            end else if (with_sat && i / 4 == SAT_FRAME + 1) begin
                v = 16'h7fff;
            end
            in_hist.push_back(v);
            model0.in_q.push_back(v);
        end
    endtask

    task automatic power_up(input string name);
        int n;
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        check_eq({name, " pdn in reset"}, 32'd0, {31'd0, pdn});
        check_eq({name, " sdin1 in reset"}, 32'd0, {31'd0, sdin1});
        check_eq({name, " bick in reset"}, 32'd0, {31'd0, bick});
        check_eq({name, " lrck in reset"}, 32'd1, {31'd0, lrck});
        arst_n = 1'b1;
        n = 0;
        while (!pdn && n < 4 * `EP_FRAME_CLKS) begin
            @(negedge clk);
            n++;
        end
        check_eq({name, " pdn low cycles"}, 32'd512, n);
        // mclk follows clk once pdn is high
        mclk_edges = 0;
        repeat (4) @(negedge clk);
        check_eq({name, " mclk running"}, 32'd4, mclk_edges);
    endtask

    task automatic check_outputs(input int frames, input string name);
        string tname;
        logic [15:0] exp;
        while (model0.out_q.size() < frames * 4) begin
            @(negedge clk);
        end
        for (int i = 0; i < frames * 4; i++) begin
            if (i / 4 < QUIET_FRAMES) begin
                tname = "power-up zero";
                exp   = 16'h0000;
            end else begin
                tname = (in_hist[i - 8] == 16'h8000 || in_hist[i - 8] == 16'h7fff)
                      ? "saturation" : name;
                exp   = expected_out(in_hist[i - 8], i % 4);
            end
            check_eq($sformatf("%s slot %0d", tname, i), {16'd0, exp}, {16'd0, model0.out_q[i]});
        end
    endtask

    // Framing monitor
    always @(negedge clk) begin
        if (!arst_n) begin
            mon_valid = 1'b0;
            lr_seen   = 1'b0;
        end else begin
            if (mon_valid) begin
                check_eq("bick toggle", {31'd0, ~prev_bick}, {31'd0, bick});
                lr_per++;
                if (lrck) begin
                    lr_high++;
                end
                if (lrck && !prev_lrck) begin
                    if (lr_seen) begin
                        check_eq("lrck period", 32'd256, lr_per);
                        check_eq("lrck high", 32'd128, lr_high);
                    end
                    lr_seen = 1'b1;
                    lr_per  = 0;
                    lr_high = 0;
                end
            end
            prev_bick = bick;
            prev_lrck = lrck;
            mon_valid = 1'b1;
        end
    end

    always @(posedge mclk) begin
        if (!pdn) begin
            $display("mclk toggled while pdn was low");
            $display("TEST FAIL");
            $fatal(1, "mclk active in power-down");
        end else begin
            mclk_edges++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d clock cycles", cycles);
            $display("TEST FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        lfsr   = 32'hd8ef;
        cycles = 0;

        // Power-up, framing, loopback and saturation in one run
        fill_inputs(RUN1_FRAMES, 1'b1);
        power_up("power-up");
        check_outputs(RUN1_FRAMES, "loopback");

        // Reset in the middle of a frame, then the whole sequence again
        repeat (100) @(negedge clk);
        arst_n = 1'b0;
        fill_inputs(RUN2_FRAMES, 1'b0);
        power_up("reset during run");
        check_outputs(RUN2_FRAMES, "reset during run");

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/eurorack_pkg.sv
hdl/tdm_timing_if.sv
hdl/codec_clock_gen.sv
hdl/codec_power_ctrl.sv
hdl/tdm_shifter.sv
hdl/sample_cal.sv
hdl/eurorack_top.sv
test/codec_model.sv
test/eurorack_tb.sv
